//--- soc_top.f
+incdir+tb
src/axi_pkg.sv
src/soc_pkg.sv
src/axi_bram_slave.sv
src/axi_xbar_1to2.sv
src/soc_top.sv
tb/soc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the soc testbench with verilator, the log decides pass or fail

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -j 0 --top-module soc_tb -f soc_top.f \
  -Mdir obj_dir -o soc_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/soc_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$log"; then
  exit 0
fi
exit 1

//--- tb/soc_tb_tasks.svh
`ifndef soc_tb_tasks_svh
`define soc_tb_tasks_svh

// reference model, one word array per region
axi_data_t main_model  [main_words];
axi_data_t accel_model [accel_words];
// set once a word has been written with all four bytes
logic      main_known  [main_words];
logic      accel_known [accel_words];
// response that the next b or r handshake must carry
axi_b_t    exp_b;
axi_r_t    exp_r;

// regions are power of two sized and aligned
function automatic slave_sel_e region_of(input axi_addr_t addr);
  if ((addr & ~(main_span - 1)) == main_base) return sel_main;
  if ((addr & ~(accel_span - 1)) == accel_base) return sel_accel;
  return sel_none;
endfunction

// word behind a byte address, a small memory wraps around
function automatic int word_index(input axi_addr_t addr, input int depth);
  return int'(addr[31:2]) % depth;
endfunction

function automatic logic word_known(input axi_addr_t addr);
  case (region_of(addr))
    sel_main:  return main_known[word_index(addr, main_words)];
    sel_accel: return accel_known[word_index(addr, accel_words)];
    default:   return 1'b1;
  endcase
endfunction

// model update and expected b response
function automatic void apply_write(input axi_addr_t addr, input axi_data_t data,
                                    input axi_strb_t strb);
  slave_sel_e sel;
  axi_data_t  incoming;
  axi_data_t  word;
  int         idx;
  sel = region_of(addr);
  exp_b.resp = resp_okay;
  if (sel == sel_none) begin
    // nothing is stored for an unmapped write
    exp_b.resp = resp_decerr;
    return;
  end
  // scratchpad adds its offset before the strobe merge
  incoming = (sel == sel_accel) ? data + accel_wr_offset : data;
  idx = word_index(addr, (sel == sel_accel) ? accel_words : main_words);
  word = (sel == sel_accel) ? accel_model[idx] : main_model[idx];
  for (int i = 0; i < 4; i++) begin
    if (strb[i]) begin
      word[8*i +: 8] = incoming[8*i +: 8];
    end
  end
  if (sel == sel_accel) begin
    accel_model[idx] = word;
    accel_known[idx] = accel_known[idx] || (strb == 4'hf);
  end else begin
    main_model[idx] = word;
    main_known[idx] = main_known[idx] || (strb == 4'hf);
  end
endfunction

// expected r payload, zero data on a decode error
function automatic void expect_read(input axi_addr_t addr);
  case (region_of(addr))
    sel_main:  exp_r = '{data: main_model[word_index(addr, main_words)], resp: resp_okay};
    sel_accel: exp_r = '{data: accel_model[word_index(addr, accel_words)], resp: resp_okay};
    default:   exp_r = '{data: '0, resp: resp_decerr};
  endcase
endfunction

// order 0 sends aw and w together, 1 aw first, 2 w first
// hold is the number of cycles that s_b_ready stays low once bvalid is due
task automatic write_txn(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                         input int order, input int hold);
  logic aw_left;
  logic w_left;
  @(negedge clk);
  apply_write(addr, data, strb);
  s_aw = '{addr: addr};
  s_w = '{data: data, strb: strb};
  s_aw_valid = (order != 2);
  s_w_valid = (order != 1);
  s_b_ready = (hold == 0);
  aw_left = 1'b1;
  w_left = 1'b1;
  while (aw_left || w_left) begin
    @(posedge clk);
    if (s_aw_valid && s_aw_ready) aw_left = 1'b0;
    if (s_w_valid && s_w_ready) w_left = 1'b0;
    @(negedge clk);
    // the held back channel comes up one cycle late
    s_aw_valid = aw_left;
    s_w_valid = w_left;
  end
  repeat (hold) @(negedge clk);
  s_b_ready = 1'b1;
  @(posedge clk);
  while (!(s_b_valid && s_b_ready)) @(posedge clk);
endtask

// hold is the number of cycles that s_r_ready stays low once rvalid is due
task automatic read_txn(input axi_addr_t addr, input int hold);
  @(negedge clk);
  expect_read(addr);
  s_ar = '{addr: addr};
  s_ar_valid = 1'b1;
  s_r_ready = (hold == 0);
  @(posedge clk);
  while (!(s_ar_valid && s_ar_ready)) @(posedge clk);
  @(negedge clk);
  s_ar_valid = 1'b0;
  repeat (hold) @(negedge clk);
  s_r_ready = 1'b1;
  @(posedge clk);
  while (!(s_r_valid && s_r_ready)) @(posedge clk);
endtask

`endif

//--- tb/soc_tb.sv
`default_nettype none
`timescale 1ns/1ps

// testbench for the memory fabric where the testbench plays the cpu
module soc_tb
  import axi_pkg::*;
  import soc_pkg::*;
();

  // about four times the 750 cycles of the random mix
  localparam int timeout_cycles = 3000;

  logic    clk;
  logic    rst_n;
  axi_aw_t s_aw;
  logic    s_aw_valid;
  logic    s_aw_ready;
  axi_w_t  s_w;
  logic    s_w_valid;
  logic    s_w_ready;
  axi_b_t  s_b;
  logic    s_b_valid;
  logic    s_b_ready;
  axi_ar_t s_ar;
  logic    s_ar_valid;
  logic    s_ar_ready;
  axi_r_t  s_r;
  logic    s_r_valid;
  logic    s_r_ready;

  int seed;
  int errors = 0;
  int errors_at_start = 0;
  int cycles = 0;
  int tests_run = 0;
  int tests_bad = 0;

  // handshakes seen on the master port
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic aw_seen;
  logic w_seen;
  logic ar_seen;
  // second half of a write lands this cycle
  logic wr_last_hs;

  `include "soc_tb_tasks.svh"

  soc_top u_dut (.*);

  always #20 clk = ~clk;

  assign aw_hs = s_aw_valid && s_aw_ready;
  assign w_hs  = s_w_valid && s_w_ready;
  assign b_hs  = s_b_valid && s_b_ready;
  assign ar_hs = s_ar_valid && s_ar_ready;
  assign r_hs  = s_r_valid && s_r_ready;
  assign wr_last_hs = (aw_hs || aw_seen) && (w_hs || w_seen) && (aw_hs || w_hs);

  always @(posedge clk) begin
    if (!rst_n) begin
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
      ar_seen <= 1'b0;
    end else begin
      if (aw_hs) aw_seen <= 1'b1;
      if (w_hs) w_seen <= 1'b1;
      // a write is over once its response is taken
      if (b_hs) begin
        aw_seen <= 1'b0;
        w_seen  <= 1'b0;
      end
      if (ar_hs) begin
        ar_seen <= 1'b1;
      end else if (r_hs) begin
        ar_seen <= 1'b0;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("Fail at %0d ns: %s expected %h got %h", $time, name, expected, actual);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("error at %0d ns: %s", $time, what);
  endtask

  function automatic logic [31:0] draw();
    return $random(seed);
  endfunction

  reset_idle_chk: assert property (@(posedge clk) $rose(rst_n) |->
      !s_b_valid && !s_r_valid && s_aw_ready && s_w_ready && s_ar_ready)
    else report_problem("handshake outputs were not idle right after reset");

  b_resp_chk: assert property (@(posedge clk) disable iff (!rst_n)
      s_b_valid |-> s_b.resp == exp_b.resp)
    else report_mismatch("s_b.resp", 32'($sampled(exp_b.resp)), 32'($sampled(s_b.resp)));

  r_resp_chk: assert property (@(posedge clk) disable iff (!rst_n)
      s_r_valid |-> s_r.resp == exp_r.resp)
    else report_mismatch("s_r.resp", 32'($sampled(exp_r.resp)), 32'($sampled(s_r.resp)));

  r_data_chk: assert property (@(posedge clk) disable iff (!rst_n)
      s_r_valid |-> s_r.data == exp_r.data)
    else report_mismatch("s_r.data", $sampled(exp_r.data), $sampled(s_r.data));

  // responses wait unchanged while ready is low
  b_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
      s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
    else report_problem("write response dropped or changed before its handshake");

  r_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
      s_r_valid && !s_r_ready |=> s_r_valid && $stable(s_r))
    else report_problem("read response dropped or changed before its handshake");

  // one cycle from the last request handshake to the response
  b_timing_chk: assert property (@(posedge clk) disable iff (!rst_n)
      wr_last_hs |=> s_b_valid)
    else report_problem("s_b_valid did not rise one cycle after the write handshakes");

  b_early_chk: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(s_b_valid) |-> $past(wr_last_hs))
    else report_problem("s_b_valid rose without a completed write the cycle before");

  r_timing_chk: assert property (@(posedge clk) disable iff (!rst_n)
      ar_hs |=> s_r_valid)
    else report_problem("s_r_valid did not rise one cycle after the ar handshake");

  r_early_chk: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(s_r_valid) |-> $past(ar_hs))
    else report_problem("s_r_valid rose without an ar handshake the cycle before");

  // only one write and one read in flight
  aw_busy_chk: assert property (@(posedge clk) disable iff (!rst_n)
      aw_seen |-> !s_aw_ready)
    else report_problem("s_aw_ready high while a write was still open");

  ar_busy_chk: assert property (@(posedge clk) disable iff (!rst_n)
      ar_seen |-> !s_ar_ready)
    else report_problem("s_ar_ready high while a read was still open");

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // late assertion results still count for the test that caused them
  task automatic test_done(input string name);
    @(negedge clk);
    tests_run++;
    if (errors != errors_at_start) tests_bad++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // full words first and then partial strobes on top of them
  task automatic main_mem_rw();
    axi_addr_t addr;
    for (int i = 0; i < 8; i++) begin
      addr = main_base + axi_addr_t'(i * 148);
      write_txn(addr, draw(), 4'hf, i % 3, 0);
      read_txn(addr, 0);
      write_txn(addr, draw(), axi_strb_t'(i + 1), (i + 1) % 3, 0);
      read_txn(addr, 0);
    end
  endtask

  task automatic scratch_offset();
    for (int i = 0; i < 8; i++) begin
      write_txn(accel_base + axi_addr_t'(4 * i), draw(), 4'hf, i % 3, 0);
      read_txn(accel_base + axi_addr_t'(4 * i), 0);
    end
    // all ones wraps to zero
    write_txn(accel_base, 32'hffff_ffff, 4'hf, 0, 0);
    read_txn(accel_base, 0);
    // carry out of byte 0 is lost under the strobe
    write_txn(accel_base + 4, 32'h0000_00ff, 4'b0001, 1, 0);
    read_txn(accel_base + 4, 0);
    write_txn(accel_base + 8, 32'h0102_0304, 4'b1100, 2, 0);
    read_txn(accel_base + 8, 0);
  endtask

  // word 5 of the scratchpad shows up every 128 bytes
  task automatic scratch_alias();
    write_txn(main_base + 20, 32'h5a5a_0005, 4'hf, 0, 0);
    write_txn(accel_base + 20, 32'h0c0d_0005, 4'hf, 1, 0);
    read_txn(accel_base + 20 + 128, 0);
    read_txn(accel_base + 20 + 128 * 31, 0);
    read_txn(main_base + 20, 0);
    write_txn(accel_base + 20 + 2048, 32'h7777_0000, 4'hf, 2, 0);
    read_txn(accel_base + 20, 0);
    read_txn(main_base + 20, 0);
  endtask

  task automatic unmapped_access();
    write_txn(32'h4000_0000, 32'hdead_beef, 4'hf, 0, 0);
    read_txn(32'h4000_0000, 0);
    // just past each region
    write_txn(accel_base + accel_span, 32'h1111_2222, 4'hf, 2, 0);
    read_txn(main_base + main_span, 0);
    // word 0 is where a leaked unmapped write would land in either memory
    read_txn(main_base, 0);
    read_txn(accel_base, 0);
  endtask

  task automatic back_pressure();
    axi_addr_t   addr;
    logic [31:0] r;
    for (int i = 0; i < 6; i++) begin
      r = draw();
      if (i % 2 == 0) begin
        addr = main_base + axi_addr_t'(400 + 4 * i);
      end else begin
        addr = accel_base + axi_addr_t'(4 * i);
      end
      write_txn(addr, r, 4'hf, i % 3, 1 + int'(r[2:0]));
      r = draw();
      read_txn(addr, 1 + int'(r[5:3]));
    end
    // decode error responses wait as well
    write_txn(32'h4000_0010, 32'h3c3c_3c3c, 4'hf, 1, 3);
    read_txn(32'h4000_0010, 4);
  endtask

  task automatic random_mix();
    axi_addr_t   addr;
    axi_strb_t   strb;
    logic [31:0] r;
    for (int n = 0; n < 200; n++) begin
      r = draw();
      case (int'(r[1:0]) % 3)
        0: addr = main_base + axi_addr_t'({r[7:2], 2'b00});
        1: addr = accel_base + axi_addr_t'({r[11:2], 2'b00});
        default: begin
          if (r[12]) begin
            addr = 32'h4000_0000 + axi_addr_t'({r[11:2], 2'b00});
          end else begin
            addr = accel_base + accel_span + axi_addr_t'({r[11:2], 2'b00});
          end
        end
      endcase
      // a word never written whole is written whole before any read
      strb = word_known(addr) ? r[16:13] : 4'hf;
      if (r[19] || !word_known(addr)) begin
        write_txn(addr, draw(), strb, int'(r[18:17]) % 3, 0);
      end else begin
        read_txn(addr, 0);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    s_aw = '0;
    s_aw_valid = 1'b0;
    s_w = '0;
    s_w_valid = 1'b0;
    s_b_ready = 1'b1;
    s_ar = '0;
    s_ar_valid = 1'b0;
    s_r_ready = 1'b1;
    seed = 32'hdc65;
    foreach (main_known[i]) main_known[i] = 1'b0;
    foreach (accel_known[i]) accel_known[i] = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    main_mem_rw();
    test_done("main memory words and strobes");
    scratch_offset();
    test_done("scratchpad write offset");
    scratch_alias();
    test_done("scratchpad aliasing");
    unmapped_access();
    test_done("decode error");
    back_pressure();
    test_done("response back-pressure");
    random_mix();
    test_done("random mix");

    $display("%0d tests, %0d with errors, %0d errors in total", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/soc_top.sv
`default_nettype none
`timescale 1ns/1ps

// memory fabric: crossbar in front of main memory and the scratchpad
module soc_top
  import axi_pkg::*;
  import soc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  axi_aw_t s_aw,
  input  logic    s_aw_valid,
  output logic    s_aw_ready,
  input  axi_w_t  s_w,
  input  logic    s_w_valid,
  output logic    s_w_ready,
  output axi_b_t  s_b,
  output logic    s_b_valid,
  input  logic    s_b_ready,
  input  axi_ar_t s_ar,
  input  logic    s_ar_valid,
  output logic    s_ar_ready,
  output axi_r_t  s_r,
  output logic    s_r_valid,
  input  logic    s_r_ready
);

  // crossbar to main memory
  axi_aw_t main_aw;
  axi_w_t  main_w;
  axi_b_t  main_b;
  axi_ar_t main_ar;
  axi_r_t  main_r;
  logic    main_aw_valid, main_aw_ready, main_w_valid, main_w_ready;
  logic    main_b_valid, main_b_ready, main_ar_valid, main_ar_ready;
  logic    main_r_valid, main_r_ready;

  // crossbar to scratchpad
  axi_aw_t accel_aw;
  axi_w_t  accel_w;
  axi_b_t  accel_b;
  axi_ar_t accel_ar;
  axi_r_t  accel_r;
  logic    accel_aw_valid, accel_aw_ready, accel_w_valid, accel_w_ready;
  logic    accel_b_valid, accel_b_ready, accel_ar_valid, accel_ar_ready;
  logic    accel_r_valid, accel_r_ready;

  // port names line up one to one
  axi_xbar_1to2 u_xbar (.*);

  // plain data memory
  axi_bram_slave #(
    .depth_words (main_words),
    .wr_offset   ('0)
  ) u_main_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (main_aw),
    .aw_valid (main_aw_valid),
    .aw_ready (main_aw_ready),
    .w        (main_w),
    .w_valid  (main_w_valid),
    .w_ready  (main_w_ready),
    .b        (main_b),
    .b_valid  (main_b_valid),
    .b_ready  (main_b_ready),
    .ar       (main_ar),
    .ar_valid (main_ar_valid),
    .ar_ready (main_ar_ready),
    .r        (main_r),
    .r_valid  (main_r_valid),
    .r_ready  (main_r_ready)
  );

  // scratchpad adds one to each stored word and aliases every 128 bytes
  axi_bram_slave #(
    .depth_words (accel_words),
    .wr_offset   (accel_wr_offset)
  ) u_accel_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (accel_aw),
    .aw_valid (accel_aw_valid),
    .aw_ready (accel_aw_ready),
    .w        (accel_w),
    .w_valid  (accel_w_valid),
    .w_ready  (accel_w_ready),
    .b        (accel_b),
    .b_valid  (accel_b_valid),
    .b_ready  (accel_b_ready),
    .ar       (accel_ar),
    .ar_valid (accel_ar_valid),
    .ar_ready (accel_ar_ready),
    .r        (accel_r),
    .r_valid  (accel_r_valid),
    .r_ready  (accel_r_ready)
  );

endmodule

`default_nettype wire

//--- src/axi_xbar_1to2.sv
`default_nettype none
`timescale 1ns/1ps

// one master to two slaves, with a local decode error responder
module axi_xbar_1to2
  import axi_pkg::*;
  import soc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // upstream, from the master
  input  axi_aw_t s_aw,
  input  logic    s_aw_valid,
  output logic    s_aw_ready,
  input  axi_w_t  s_w,
  input  logic    s_w_valid,
  output logic    s_w_ready,
  output axi_b_t  s_b,
  output logic    s_b_valid,
  input  logic    s_b_ready,
  input  axi_ar_t s_ar,
  input  logic    s_ar_valid,
  output logic    s_ar_ready,
  output axi_r_t  s_r,
  output logic    s_r_valid,
  input  logic    s_r_ready,
  // main memory side
  output axi_aw_t main_aw,
  output logic    main_aw_valid,
  input  logic    main_aw_ready,
  output axi_w_t  main_w,
  output logic    main_w_valid,
  input  logic    main_w_ready,
  input  axi_b_t  main_b,
  input  logic    main_b_valid,
  output logic    main_b_ready,
  output axi_ar_t main_ar,
  output logic    main_ar_valid,
  input  logic    main_ar_ready,
  input  axi_r_t  main_r,
  input  logic    main_r_valid,
  output logic    main_r_ready,
  // scratchpad side
  output axi_aw_t accel_aw,
  output logic    accel_aw_valid,
  input  logic    accel_aw_ready,
  output axi_w_t  accel_w,
  output logic    accel_w_valid,
  input  logic    accel_w_ready,
  input  axi_b_t  accel_b,
  input  logic    accel_b_valid,
  output logic    accel_b_ready,
  output axi_ar_t accel_ar,
  output logic    accel_ar_valid,
  input  logic    accel_ar_ready,
  input  axi_r_t  accel_r,
  input  logic    accel_r_valid,
  output logic    accel_r_ready
);

  // wrapping subtract covers both bounds with one compare
  function automatic slave_sel_e decode(axi_addr_t addr);
    if ((addr - main_base) < main_span) return sel_main;
    if ((addr - accel_base) < accel_span) return sel_accel;
    return sel_none;
  endfunction

  // ready of the chosen target, the error responder always takes
  function automatic logic pick_ready(slave_sel_e sel, logic m_rdy, logic a_rdy);
    if (sel == sel_main) return m_rdy;
    if (sel == sel_accel) return a_rdy;
    return 1'b1;
  endfunction

  // write tracking, cleared on the b handshake
  logic       aw_done;
  logic       w_sent;
  logic       w_buf_vld;
  logic       dec_bvalid;
  slave_sel_e wr_sel_q;
  axi_w_t     w_buf_q;
  // read tracking, cleared on the r handshake
  logic       ar_done;
  logic       dec_rvalid;
  slave_sel_e rd_sel_q;

  slave_sel_e aw_tgt;
  slave_sel_e ar_tgt;
  slave_sel_e w_tgt;
  logic       w_tgt_known;
  axi_w_t     w_src;
  logic       w_src_valid;
  logic       w_dn_valid;
  logic       w_dn_fire;
  logic       s_w_fire;
  logic       aw_fire;
  logic       ar_fire;
  logic       b_fire;
  logic       r_fire;
  logic       dec_b_set;

  assign aw_tgt = decode(s_aw.addr);
  assign ar_tgt = decode(s_ar.addr);

  // w follows the latched aw target, or the one on the bus right now
  assign w_tgt       = aw_done ? wr_sel_q : aw_tgt;
  assign w_tgt_known = aw_done || s_aw_valid;

  // data that came ahead of its address waits in the local buffer
  assign w_src       = w_buf_vld ? w_buf_q : s_w;
  assign w_src_valid = w_buf_vld || (s_w_valid && !w_sent);
  assign w_dn_valid  = w_src_valid && w_tgt_known;
  assign w_dn_fire   = w_dn_valid && pick_ready(w_tgt, main_w_ready, accel_w_ready);

  // address ready stays low from acceptance to response
  assign s_aw_ready = !aw_done && pick_ready(aw_tgt, main_aw_ready, accel_aw_ready);
  // unknown target means the beat goes to the buffer
  assign s_w_ready  = !w_buf_vld && !w_sent &&
                      (w_tgt_known ? pick_ready(w_tgt, main_w_ready, accel_w_ready) : 1'b1);
  assign s_ar_ready = !ar_done && pick_ready(ar_tgt, main_ar_ready, accel_ar_ready);

  assign aw_fire  = s_aw_valid && s_aw_ready;
  assign s_w_fire = s_w_valid && s_w_ready;
  assign ar_fire  = s_ar_valid && s_ar_ready;
  assign b_fire   = s_b_valid && s_b_ready;
  assign r_fire   = s_r_valid && s_r_ready;

  // unmapped write answers once both halves are in
  assign dec_b_set = (aw_done || aw_fire) && (w_sent || w_dn_fire) &&
                     (w_tgt == sel_none) && !dec_bvalid;

  // forward valid and payload to the selected slave only
  assign main_aw_valid  = s_aw_valid && !aw_done && (aw_tgt == sel_main);
  assign accel_aw_valid = s_aw_valid && !aw_done && (aw_tgt == sel_accel);
  assign main_aw        = main_aw_valid ? s_aw : '0;
  assign accel_aw       = accel_aw_valid ? s_aw : '0;

  assign main_w_valid  = w_dn_valid && (w_tgt == sel_main);
  assign accel_w_valid = w_dn_valid && (w_tgt == sel_accel);
  assign main_w        = main_w_valid ? w_src : '0;
  assign accel_w       = accel_w_valid ? w_src : '0;

  assign main_ar_valid  = s_ar_valid && !ar_done && (ar_tgt == sel_main);
  assign accel_ar_valid = s_ar_valid && !ar_done && (ar_tgt == sel_accel);
  assign main_ar        = main_ar_valid ? s_ar : '0;
  assign accel_ar       = accel_ar_valid ? s_ar : '0;

  // responses steered back by the latched targets
  assign main_b_ready  = s_b_ready && aw_done && (wr_sel_q == sel_main);
  assign accel_b_ready = s_b_ready && aw_done && (wr_sel_q == sel_accel);
  assign main_r_ready  = s_r_ready && ar_done && (rd_sel_q == sel_main);
  assign accel_r_ready = s_r_ready && ar_done && (rd_sel_q == sel_accel);

  always_comb begin
    case (wr_sel_q)
      sel_main: begin
        s_b       = main_b;
        s_b_valid = aw_done && main_b_valid;
      end
      sel_accel: begin
        s_b       = accel_b;
        s_b_valid = aw_done && accel_b_valid;
      end
      default: begin
        s_b       = '{resp: resp_decerr};
        s_b_valid = aw_done && dec_bvalid;
      end
    endcase
    case (rd_sel_q)
      sel_main: begin
        s_r       = main_r;
        s_r_valid = ar_done && main_r_valid;
      end
      sel_accel: begin
        s_r       = accel_r;
        s_r_valid = ar_done && accel_r_valid;
      end
      default: begin
        // zero data on a decode error
        s_r       = '{data: '0, resp: resp_decerr};
        s_r_valid = ar_done && dec_rvalid;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_done    <= 1'b0;
      w_sent     <= 1'b0;
      w_buf_vld  <= 1'b0;
      dec_bvalid <= 1'b0;
      wr_sel_q   <= sel_none;
      ar_done    <= 1'b0;
      dec_rvalid <= 1'b0;
      rd_sel_q   <= sel_none;
    end else begin
      if (aw_fire) begin
        aw_done  <= 1'b1;
        wr_sel_q <= aw_tgt;
      end
      // buffer only when no target was known for the beat
      if (s_w_fire && !w_dn_fire) begin
        w_buf_vld <= 1'b1;
      end
      if (w_dn_fire) begin
        w_buf_vld <= 1'b0;
        w_sent    <= 1'b1;
      end
      if (dec_b_set) begin
        dec_bvalid <= 1'b1;
      end
      if (b_fire) begin
        aw_done    <= 1'b0;
        w_sent     <= 1'b0;
        dec_bvalid <= 1'b0;
      end
      if (ar_fire) begin
        ar_done    <= 1'b1;
        rd_sel_q   <= ar_tgt;
        dec_rvalid <= (ar_tgt == sel_none);
      end
      if (r_fire) begin
        ar_done    <= 1'b0;
        dec_rvalid <= 1'b0;
      end
    end
  end

  // early write data
  always_ff @(posedge clk) begin
    if (s_w_fire) begin
      w_buf_q <= s_w;
    end
  end

endmodule

`default_nettype wire

//--- src/axi_bram_slave.sv
`default_nettype none
`timescale 1ns/1ps

// single-beat axi slave in front of a word-addressed block ram
module axi_bram_slave
  import axi_pkg::*;
#(
  parameter int        depth_words = 1024,
  parameter axi_data_t wr_offset   = '0
) (
  input  logic    clk,
  input  logic    rst_n,
  // write address
  input  axi_aw_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  // write data
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  // write response
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready,
  // read address
  input  axi_ar_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  // read data
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready
);

  localparam int idx_w = $clog2(depth_words);

  // word index inside the ram
  typedef logic [idx_w-1:0] ram_idx_t;

  axi_data_t ram [depth_words];

  // aw and w can land in either order, so each side is held on its own
  axi_aw_t   aw_q;
  axi_w_t    w_q;
  logic      aw_held;
  logic      w_held;
  logic      bvalid_q;
  logic      rvalid_q;
  axi_data_t rdata_q;

  logic      aw_fire;
  logic      w_fire;
  logic      ar_fire;
  logic      wr_commit;
  axi_addr_t wr_addr;
  axi_w_t    wr_beat;
  axi_data_t wr_data_inc;
  ram_idx_t  wr_idx;
  ram_idx_t  rd_idx;

  // one write in flight, blocked until its response is taken
  assign aw_ready = !aw_held && !bvalid_q;
  assign w_ready  = !w_held && !bvalid_q;
  // one read in flight
  assign ar_ready = !rvalid_q;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign ar_fire = ar_valid && ar_ready;

  // take whichever half is still on the bus this cycle
  assign wr_addr = aw_held ? aw_q.addr : aw.addr;
  assign wr_beat = w_held ? w_q : w;

  // commit on the edge where the second half arrives
  assign wr_commit = (aw_held || aw_fire) && (w_held || w_fire);

  // offset goes in before the strobe merge
  assign wr_data_inc = wr_beat.data + wr_offset;

  // low word bits only, so a small ram aliases across its region
  assign wr_idx = wr_addr[axi_byte_off +: idx_w];
  assign rd_idx = ar.addr[axi_byte_off +: idx_w];

  // handshake state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_commit) begin
        aw_held  <= 1'b0;
        w_held   <= 1'b0;
        bvalid_q <= 1'b1;
      end else begin
        if (aw_fire) begin
          aw_held <= 1'b1;
        end
        if (w_fire) begin
          w_held <= 1'b1;
        end
        // response leaves on its handshake
        if (b_ready) begin
          bvalid_q <= 1'b0;
        end
      end
      if (ar_fire) begin
        rvalid_q <= 1'b1;
      end else if (r_ready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // payload holding for the early half of a write
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_q <= aw;
    end
    if (w_fire) begin
      w_q <= w;
    end
  end

  // ram with byte enables and a registered read port
  always_ff @(posedge clk) begin
    if (wr_commit) begin
      for (int i = 0; i < axi_strb_w; i++) begin
        if (wr_beat.strb[i]) begin
          ram[wr_idx][8*i +: 8] <= wr_data_inc[8*i +: 8];
        end
      end
    end
    // read data stays put while rvalid waits for ready
    if (ar_fire) begin
      rdata_q <= ram[rd_idx];
    end
  end

  assign b       = '{resp: resp_okay};
  assign b_valid = bvalid_q;
  assign r       = '{data: rdata_q, resp: resp_okay};
  assign r_valid = rvalid_q;

endmodule

`default_nettype wire

//--- src/soc_pkg.sv
`default_nettype none

// address map and memory sizing of the soc
package soc_pkg;

  import axi_pkg::*;

  // main data memory, 1024 words
  localparam axi_addr_t main_base = 32'h0000_0000;
  localparam axi_addr_t main_span = 32'h0000_1000;

  // accelerator scratchpad region, only 32 words behind it
  localparam axi_addr_t accel_base = 32'h8000_0000;
  localparam axi_addr_t accel_span = 32'h0000_1000;

  // ram depths in words
  localparam int main_words  = 1024;
  localparam int accel_words = 32;

  // scratchpad stores each written word plus this value
  localparam axi_data_t accel_wr_offset = 32'd1;

  // crossbar target
  typedef enum logic [1:0] {
    sel_main  = 2'd0,
    sel_accel = 2'd1,
    sel_none  = 2'd2
  } slave_sel_e;

endpackage

`default_nettype wire

//--- src/axi_pkg.sv
`default_nettype none

// single-beat axi channel payloads shared by the fabric and its slaves
package axi_pkg;

  // bus widths
  localparam int axi_addr_w = 32;
  localparam int axi_data_w = 32;
  localparam int axi_strb_w = axi_data_w / 8;
  // low address bits that select a byte inside a word
  localparam int axi_byte_off = 2;

  typedef logic [axi_addr_w-1:0] axi_addr_t;
  typedef logic [axi_data_w-1:0] axi_data_t;
  typedef logic [axi_strb_w-1:0] axi_strb_t;

  // only okay and decode error are ever produced here
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_decerr = 2'b11
  } axi_resp_e;

  // write address channel
  typedef struct packed {
    axi_addr_t addr;
  } axi_aw_t;

  // write data channel, strb bit i enables byte i
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  // write response channel
  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

  // read address channel
  typedef struct packed {
    axi_addr_t addr;
  } axi_ar_t;

  // read data channel
  typedef struct packed {
    axi_data_t data;
    axi_resp_e resp;
  } axi_r_t;

endpackage

`default_nettype wire
